/* design/bp_config.svh */
`ifndef BP_CONFIG_SVH
`define BP_CONFIG_SVH

// word address width of fetch and execute pc
`define BP_ADDR_WIDTH 30

// index width of every table, also the history length
`define BP_INDEX_WIDTH 10

// entries per table
`define BP_TABLE_DEPTH (1 << `BP_INDEX_WIDTH)

// counter value after reset
// weakly not taken, or weakly local in the chooser
`define BP_CTR_INIT 2'd1

`endif

/* design/bp_pkg.sv */
`default_nettype none

package bp_pkg;

    // branch kind reported by the decoder
    // code 7 is unused and decodes like not_jump
    typedef enum logic [2:0] {
        not_jump      = 3'd0,
        direct_jump   = 3'd1,
        jump          = 3'd2,
        call          = 3'd3,
        ret           = 3'd4,
        indirect_jump = 3'd5,
        other_jump    = 3'd6
    } branch_kind_t;

    // 2-bit saturating counter
    // high bit set means taken in the direction tables
    // and means pick gshare in the chooser
    typedef logic [1:0] counter_t;

endpackage

`default_nettype wire

/* design/branch_predictor_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bp_config.svh"

module branch_predictor_top (
    input  wire                       clk,
    input  wire                       rst,
    // fetch side lookup
    input  wire [`BP_ADDR_WIDTH-1:0]  pc,
    input  wire bp_pkg::branch_kind_t kind_pdc,
    output logic                      taken_pdc,
    output logic                      choice_g,
    output logic                      taken_b_pdc,
    output logic                      taken_g_pdc,
    // execute side resolution
    input  wire                       update_en,
    input  wire [`BP_ADDR_WIDTH-1:0]  pc_ex,
    input  wire bp_pkg::branch_kind_t kind_ex,
    input  wire                       taken_real,
    input  wire                       taken_b_ex,
    input  wire                       taken_g_ex
);

    logic [`BP_INDEX_WIDTH-1:0] local_idx;
    logic [`BP_INDEX_WIDTH-1:0] gshare_idx;
    logic [`BP_INDEX_WIDTH-1:0] choice_idx;
    logic [`BP_INDEX_WIDTH-1:0] local_idx_ex;
    logic [`BP_INDEX_WIDTH-1:0] gshare_idx_ex;
    logic [`BP_INDEX_WIDTH-1:0] choice_idx_ex;
    logic                       train;

    // histories and index hashing
    history_unit history_unit_i (
        .clk           (clk),
        .rst           (rst),
        .pc            (pc),
        .pc_ex         (pc_ex),
        .train         (train),
        .taken_real    (taken_real),
        .local_idx     (local_idx),
        .gshare_idx    (gshare_idx),
        .choice_idx    (choice_idx),
        .local_idx_ex  (local_idx_ex),
        .gshare_idx_ex (gshare_idx_ex),
        .choice_idx_ex (choice_idx_ex)
    );

    // counter tables and final decision
    tournament_predictor tournament_predictor_i (
        .clk           (clk),
        .rst           (rst),
        .kind_pdc      (kind_pdc),
        .local_idx     (local_idx),
        .gshare_idx    (gshare_idx),
        .choice_idx    (choice_idx),
        .local_idx_ex  (local_idx_ex),
        .gshare_idx_ex (gshare_idx_ex),
        .choice_idx_ex (choice_idx_ex),
        .update_en     (update_en),
        .kind_ex       (kind_ex),
        .taken_real    (taken_real),
        .taken_b_ex    (taken_b_ex),
        .taken_g_ex    (taken_g_ex),
        .taken_pdc     (taken_pdc),
        .choice_g      (choice_g),
        .taken_b_pdc   (taken_b_pdc),
        .taken_g_pdc   (taken_g_pdc),
        .train         (train)
    );

endmodule

`default_nettype wire

/* design/counter_table.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bp_config.svh"

module counter_table #(
    parameter int index_width = `BP_INDEX_WIDTH
) (
    input  wire                   clk,
    input  wire                   rst,
    input  wire [index_width-1:0] rd_idx,
    output bp_pkg::counter_t      rd_ctr,
    input  wire                   wr_en,
    input  wire [index_width-1:0] wr_idx,
    input  wire                   wr_up
);
    import bp_pkg::*;

    localparam int depth = 1 << index_width;

    counter_t ctr_mem [0:depth-1];
    counter_t wr_old;
    counter_t wr_new;

    // lookup port, old value wins on a same-cycle write
    assign rd_ctr = ctr_mem[rd_idx];

    assign wr_old = ctr_mem[wr_idx];

    // saturating step toward the resolved direction
    always_comb begin
        wr_new = wr_old;
        if (wr_up) begin
            if (wr_old != 2'd3) begin
                wr_new = wr_old + 2'd1;
            end
        end else begin
            if (wr_old != 2'd0) begin
                wr_new = wr_old - 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < depth; i++) begin
                ctr_mem[i] <= `BP_CTR_INIT;
            end
        end else if (wr_en) begin
            ctr_mem[wr_idx] <= wr_new;
        end
    end

    // training index comes from the history unit through the predictor
    wr_idx_known_a: assert property (@(posedge clk) disable iff (rst)
        wr_en |-> !$isunknown(wr_idx))
        else $error("counter_table: write index has unknown bits");

endmodule

`default_nettype wire

/* design/history_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bp_config.svh"

module history_unit (
    input  wire                        clk,
    input  wire                        rst,
    input  wire  [`BP_ADDR_WIDTH-1:0]  pc,
    input  wire  [`BP_ADDR_WIDTH-1:0]  pc_ex,
    input  wire                        train,
    input  wire                        taken_real,
    output logic [`BP_INDEX_WIDTH-1:0] local_idx,
    output logic [`BP_INDEX_WIDTH-1:0] gshare_idx,
    output logic [`BP_INDEX_WIDTH-1:0] choice_idx,
    output logic [`BP_INDEX_WIDTH-1:0] local_idx_ex,
    output logic [`BP_INDEX_WIDTH-1:0] gshare_idx_ex,
    output logic [`BP_INDEX_WIDTH-1:0] choice_idx_ex
);

    localparam int iw = `BP_INDEX_WIDTH;

    // global history, newest outcome in bit 0
    logic [iw-1:0] ghr;

    // per-branch history, selected by low pc bits
    logic [iw-1:0] lht [0:`BP_TABLE_DEPTH-1];

    logic [iw-1:0] pc_lo;
    logic [iw-1:0] pc_ex_lo;
    logic [iw-1:0] lhist;
    logic [iw-1:0] lhist_ex;

    assign pc_lo    = pc[iw-1:0];
    assign pc_ex_lo = pc_ex[iw-1:0];

    assign lhist    = lht[pc_lo];
    assign lhist_ex = lht[pc_ex_lo];

    // fetch side hashes
    assign local_idx  = lhist;
    assign gshare_idx = pc_lo ^ ghr;
    assign choice_idx = pc_lo;

    // execute side hashes
    // recomputed from current history, nothing is carried down the pipe
    assign local_idx_ex  = lhist_ex;
    assign gshare_idx_ex = pc_ex_lo ^ ghr;
    assign choice_idx_ex = pc_ex_lo;

    // histories move only on a resolved direct branch
    always_ff @(posedge clk) begin
        if (rst) begin
            ghr <= '0;
            for (int i = 0; i < `BP_TABLE_DEPTH; i++) begin
                lht[i] <= '0;
            end
        end else if (train) begin
            ghr           <= {ghr[iw-2:0], taken_real};
            lht[pc_ex_lo] <= {lhist_ex[iw-2:0], taken_real};
        end
    end

    // train strobe is qualified in the tournament predictor
    train_in_reset_a: assert property (@(posedge clk) rst |-> !train)
        else $error("history_unit: train strobe high during reset");

endmodule

`default_nettype wire

/* design/tournament_predictor.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bp_config.svh"

module tournament_predictor (
    input  wire                       clk,
    input  wire                       rst,
    input  wire bp_pkg::branch_kind_t kind_pdc,
    input  wire [`BP_INDEX_WIDTH-1:0] local_idx,
    input  wire [`BP_INDEX_WIDTH-1:0] gshare_idx,
    input  wire [`BP_INDEX_WIDTH-1:0] choice_idx,
    input  wire [`BP_INDEX_WIDTH-1:0] local_idx_ex,
    input  wire [`BP_INDEX_WIDTH-1:0] gshare_idx_ex,
    input  wire [`BP_INDEX_WIDTH-1:0] choice_idx_ex,
    input  wire                       update_en,
    input  wire bp_pkg::branch_kind_t kind_ex,
    input  wire                       taken_real,
    input  wire                       taken_b_ex,
    input  wire                       taken_g_ex,
    output logic                      taken_pdc,
    output logic                      choice_g,
    output logic                      taken_b_pdc,
    output logic                      taken_g_pdc,
    output logic                      train
);
    import bp_pkg::*;

    counter_t local_ctr;
    counter_t gshare_ctr;
    counter_t choice_ctr;

    logic local_ok;
    logic gshare_ok;
    logic choice_en;

    // only resolved direct branches train, never during reset
    assign train = update_en && (kind_ex == direct_jump) && !rst;

    // which component got the resolved branch right
    assign local_ok  = (taken_b_ex == taken_real);
    assign gshare_ok = (taken_g_ex == taken_real);

    // chooser moves only when exactly one component was right
    assign choice_en = train && (local_ok != gshare_ok);

    counter_table #(.index_width(`BP_INDEX_WIDTH)) local_pht (
        .clk    (clk),
        .rst    (rst),
        .rd_idx (local_idx),
        .rd_ctr (local_ctr),
        .wr_en  (train),
        .wr_idx (local_idx_ex),
        .wr_up  (taken_real)
    );

    counter_table #(.index_width(`BP_INDEX_WIDTH)) gshare_pht (
        .clk    (clk),
        .rst    (rst),
        .rd_idx (gshare_idx),
        .rd_ctr (gshare_ctr),
        .wr_en  (train),
        .wr_idx (gshare_idx_ex),
        .wr_up  (taken_real)
    );

    // counts up toward gshare
    counter_table #(.index_width(`BP_INDEX_WIDTH)) choice_pht (
        .clk    (clk),
        .rst    (rst),
        .rd_idx (choice_idx),
        .rd_ctr (choice_ctr),
        .wr_en  (choice_en),
        .wr_idx (choice_idx_ex),
        .wr_up  (gshare_ok)
    );

    assign taken_b_pdc = local_ctr[1];
    assign taken_g_pdc = gshare_ctr[1];
    assign choice_g    = choice_ctr[1];

    // final decision by branch kind
    always_comb begin
        case (kind_pdc)
            direct_jump:   taken_pdc = choice_g ? taken_g_pdc : taken_b_pdc;
            jump:          taken_pdc = 1'b1;
            call:          taken_pdc = 1'b1;
            ret:           taken_pdc = 1'b1;
            indirect_jump: taken_pdc = 1'b1;
            // not_jump, other_jump and the unused code
            default:       taken_pdc = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+design
design/bp_pkg.sv
design/counter_table.sv
design/history_unit.sv
design/tournament_predictor.sv
design/branch_predictor_top.sv
testbench/tb_clock.sv
testbench/tb_top.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module tb_top -o tb_top_sim

# keep the output even when the simulation exits with an error
out=$(./obj_dir/tb_top_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "sim passed"; then
    exit 0
else
    exit 1
fi

/* testbench/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int half_period = 5
) (
    output logic clk
);

    // free running, first rising edge at half_period
    initial begin
        clk = 1'b0;
    end

    always #half_period clk = ~clk;

endmodule

`default_nettype wire

/* testbench/tb_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bp_config.svh"

module tb_top;
    import bp_pkg::*;

    localparam int aw = `BP_ADDR_WIDTH;
    localparam int iw = `BP_INDEX_WIDTH;
    localparam int depth = 1 << iw;
    localparam int reset_cycles = 16;
    localparam int directed_cycles = 40;
    localparam int random_cycles = 2000;
    localparam int timeout_cycles = reset_cycles + directed_cycles + random_cycles + 100;

    // some entries share low pc bits so their tables alias
    localparam logic [aw-1:0] pool [0:7] = '{
        30'h040, 30'h440, 30'h123, 30'h523, 30'h2ff, 30'h3a0, 30'h1001, 30'h7ff
    };

    logic clk;
    logic rst;
    logic [aw-1:0] pc;
    branch_kind_t kind_pdc;
    logic taken_pdc;
    logic choice_g;
    logic taken_b_pdc;
    logic taken_g_pdc;
    logic update_en;
    logic [aw-1:0] pc_ex;
    branch_kind_t kind_ex;
    logic taken_real;
    logic taken_b_ex;
    logic taken_g_ex;

    // model state
    counter_t m_local [0:depth-1];
    counter_t m_gshare [0:depth-1];
    counter_t m_choice [0:depth-1];
    logic [iw-1:0] m_lht [0:depth-1];
    logic [iw-1:0] m_ghr;

    logic [31:0] lfsr = 32'hbb78321b;
    int errors = 0;

    tb_clock clock_gen (.clk(clk));

    branch_predictor_top branch_predictor_top_i (
        .clk         (clk),
        .rst         (rst),
        .pc          (pc),
        .kind_pdc    (kind_pdc),
        .taken_pdc   (taken_pdc),
        .choice_g    (choice_g),
        .taken_b_pdc (taken_b_pdc),
        .taken_g_pdc (taken_g_pdc),
        .update_en   (update_en),
        .pc_ex       (pc_ex),
        .kind_ex     (kind_ex),
        .taken_real  (taken_real),
        .taken_b_ex  (taken_b_ex),
        .taken_g_ex  (taken_g_ex)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);
    endfunction

    task automatic random_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    function automatic counter_t sat_step(input counter_t c, input logic up);
        if (up) begin
            return (c == 2'd3) ? c : c + 2'd1;
        end
        return (c == 2'd0) ? c : c - 2'd1;
    endfunction

    // expected {taken, choice_g, local, gshare} for a lookup
    function automatic logic [3:0] predict(input logic [aw-1:0] pc_v, input branch_kind_t kind_v);
        logic [iw-1:0] lo;
        logic b;
        logic g;
        logic c;
        logic t;
        lo = pc_v[iw-1:0];
        b = m_local[m_lht[lo]][1];
        g = m_gshare[lo ^ m_ghr][1];
        c = m_choice[lo][1];
        case (kind_v)
            direct_jump: t = c ? g : b;
            jump, call, ret, indirect_jump: t = 1'b1;
            default: t = 1'b0;
        endcase
        return {t, c, b, g};
    endfunction

    task automatic model_reset();
        for (int i = 0; i < depth; i++) begin
            m_local[i] = `BP_CTR_INIT;
            m_gshare[i] = `BP_CTR_INIT;
            m_choice[i] = `BP_CTR_INIT;
            m_lht[i] = '0;
        end
        m_ghr = '0;
    endtask

    // indexes come from the histories before the edge
    task automatic model_train(input logic [aw-1:0] pe, input branch_kind_t ke, input logic upd,
                               input logic tr, input logic tb, input logic tg);
        logic [iw-1:0] lo;
        logic [iw-1:0] li;
        logic [iw-1:0] gi;
        if (upd && ke == direct_jump) begin
            lo = pe[iw-1:0];
            li = m_lht[lo];
            gi = lo ^ m_ghr;
            m_local[li] = sat_step(m_local[li], tr);
            m_gshare[gi] = sat_step(m_gshare[gi], tr);
            if ((tb == tr) != (tg == tr)) begin
                m_choice[lo] = sat_step(m_choice[lo], tg == tr);
            end
            m_ghr = {m_ghr[iw-2:0], tr};
            m_lht[lo] = {li[iw-2:0], tr};
        end
    endtask

    task automatic stop_on_error();
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        if (got !== want) begin
            errors++;
            $display("ERR %s got 0x%0h exp 0x%0h", name, got, want);
            stop_on_error();
        end
    endtask

    task automatic check_kind(input branch_kind_t kind, input logic got, input logic want);
        if (got !== want) begin
            errors++;
            $display("ERR taken_pdc kind 0x%0h got 0x%0h exp 0x%0h", kind, got, want);
            stop_on_error();
        end
    endtask

    task automatic set_inputs(input logic [aw-1:0] pc_v, input branch_kind_t kind_v,
                              input logic upd, input logic [aw-1:0] pe, input branch_kind_t ke,
                              input logic tr, input logic tb, input logic tg);
        pc = pc_v;
        kind_pdc = kind_v;
        update_en = upd;
        pc_ex = pe;
        kind_ex = ke;
        taken_real = tr;
        taken_b_ex = tb;
        taken_g_ex = tg;
    endtask

    // carried component predictions come from the model
    task automatic drive_cycle(input logic [aw-1:0] pc_v, input branch_kind_t kind_v,
                               input logic upd, input logic [aw-1:0] pe,
                               input branch_kind_t ke, input logic tr);
        logic [3:0] p;
        @(posedge clk);
        #1;
        p = predict(pe, direct_jump);
        set_inputs(pc_v, kind_v, upd, pe, ke, tr, p[1], p[0]);
    endtask

    task automatic sweep_kinds(input logic [aw-1:0] pc_v);
        for (int k = 0; k < 8; k++) begin
            drive_cycle(pc_v, branch_kind_t'(k[2:0]), 1'b0, pc_v, not_jump, 1'b0);
        end
    endtask

    // sample 1 ns before the edge, then train the model on that edge
    initial begin : compare_proc
        logic [3:0] want;
        logic rst_s;
        logic [aw-1:0] pe_s;
        branch_kind_t ke_s;
        logic upd_s;
        logic tr_s;
        logic tb_s;
        logic tg_s;
        @(posedge clk);
        forever begin
            #9;
            rst_s = rst;
            pe_s = pc_ex;
            ke_s = kind_ex;
            upd_s = update_en;
            tr_s = taken_real;
            tb_s = taken_b_ex;
            tg_s = taken_g_ex;
            if (!rst_s) begin
                want = predict(pc, kind_pdc);
                check_kind(kind_pdc, taken_pdc, want[3]);
                check_bit("choice_g", choice_g, want[2]);
                check_bit("taken_b_pdc", taken_b_pdc, want[1]);
                check_bit("taken_g_pdc", taken_g_pdc, want[0]);
            end
            @(posedge clk);
            if (rst_s) begin
                model_reset();
            end else begin
                model_train(pe_s, ke_s, upd_s, tr_s, tb_s, tg_s);
            end
        end
    end

    initial begin : watchdog
        repeat (timeout_cycles) @(posedge clk);
        $display("run timed out before the tests finished");
        stop_on_error();
    end

    initial begin : stimulus
        logic [31:0] r;
        logic [aw-1:0] pc_v;
        logic [aw-1:0] pe;
        branch_kind_t kind_v;
        branch_kind_t ke;
        logic upd;
        logic tr;
        rst = 1'b1;
        set_inputs('0, not_jump, 1'b0, '0, not_jump, 1'b0, 1'b0, 1'b0);
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst = 1'b0;

        // fresh tables predict not taken, chooser on local
        for (int i = 0; i < 4; i++) begin
            drive_cycle(pool[i * 2], direct_jump, 1'b0, pool[0], not_jump, 1'b0);
        end
        sweep_kinds(pool[2]);

        // two taken resolutions at one pc
        drive_cycle(pool[0], direct_jump, 1'b1, pool[0], direct_jump, 1'b1);
        drive_cycle(pool[0], direct_jump, 1'b1, pool[0], direct_jump, 1'b1);
        drive_cycle(pool[0], direct_jump, 1'b0, pool[0], not_jump, 1'b0);

        // resolutions that must not train
        // carried predictions say only gshare was right
        @(posedge clk);
        #1;
        set_inputs(pool[0], direct_jump, 1'b0, pool[0], direct_jump, 1'b1, 1'b0, 1'b1);
        @(posedge clk);
        #1;
        set_inputs(pool[0], direct_jump, 1'b1, pool[0], call, 1'b1, 1'b0, 1'b1);
        @(posedge clk);
        #1;
        set_inputs(pool[0], direct_jump, 1'b1, pool[0], jump, 1'b1, 1'b0, 1'b1);
        drive_cycle(pool[0], direct_jump, 1'b0, pool[0], not_jump, 1'b0);

        // only gshare right, chooser climbs toward gshare
        for (int i = 0; i < 2; i++) begin
            @(posedge clk);
            #1;
            set_inputs(pool[4], direct_jump, 1'b1, pool[4], direct_jump, 1'b1, 1'b0, 1'b1);
        end
        drive_cycle(pool[4], direct_jump, 1'b0, pool[4], not_jump, 1'b0);
        sweep_kinds(pool[4]);

        // random stream, kind_ex leans toward direct branches
        for (int n = 0; n < random_cycles; n++) begin
            random_bits(3, r);
            pc_v = pool[r[2:0]];
            random_bits(3, r);
            kind_v = branch_kind_t'(r[2:0]);
            random_bits(3, r);
            pe = pool[r[2:0]];
            random_bits(4, r);
            ke = r[3] ? direct_jump : branch_kind_t'(r[2:0]);
            random_bits(2, r);
            upd = r[1];
            tr = r[0];
            drive_cycle(pc_v, kind_v, upd, pe, ke, tr);
        end
        drive_cycle(pool[0], not_jump, 1'b0, pool[0], not_jump, 1'b0);
        repeat (2) @(posedge clk);

        if (errors == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            stop_on_error();
        end
    end

endmodule

`default_nettype wire
